/* build.f */
verilog/riscv_pkg.sv
verilog/riscv_decoder.sv
verilog/riscv_regfile.sv
verilog/riscv_alu.sv
verilog/riscv_fwd_unit.sv
verilog/riscv_datapath.sv
dv/riscv_datapath_sva.sv
dv/riscv_datapath_tb.sv

/* Bender.yml */
package:
  name: riscv_datapath

sources:
  # design, in compile order
  - files:
      - verilog/riscv_pkg.sv
      - verilog/riscv_decoder.sv
      - verilog/riscv_regfile.sv
      - verilog/riscv_alu.sv
      - verilog/riscv_fwd_unit.sv
      - verilog/riscv_datapath.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/riscv_datapath_sva.sv
      - dv/riscv_datapath_tb.sv

/* dv/riscv_datapath_tb.sv */
`timescale 1ns/100ps

module riscv_datapath_tb
  import riscv_pkg::*;
();

  localparam int          TIMEOUT = 200;        // cycles per wait loop
  localparam logic [15:0] SEED    = 16'd64933;

  logic        clk;
  logic        rst;
  logic        i_inst_valid;
  inst_t       i_inst;
  logic        o_inst_ready;
  logic        o_ret_valid;
  logic        i_ret_ready;
  reg_addr_t   o_ret_rd;
  xlen_t       o_ret_data;
  logic        o_ret_wen;
  logic        o_ret_illegal;

  xlen_t       model_regs [32];     // architectural state in acceptance order
  logic [70:0] exp_q [$];           // {illegal, wen, rd, data}
  logic [70:0] exp_e;
  logic [15:0] stim_lfsr;
  logic [15:0] rdy_lfsr;
  logic [31:0] rdy_bits;
  logic [31:0] rbits;
  logic [31:0] sbits;
  logic [6:0]  bad_opc [8];
  logic        stall_mode;
  logic        gap_mode;
  logic        held;
  reg_addr_t   snap_rd;
  xlen_t       snap_data;
  logic        snap_wen;
  logic        snap_ill;
  reg_addr_t   rd_a, rd_b, rd_c, rd_d;
  reg_addr_t   rs_a, rs_b;
  inst_t       bad_inst;
  int          n_checks, n_errors, n_retired;
  int          err0, ret0;
  string       test_name;

  riscv_datapath i_dut (
    .i_riscv_datapath_clk (clk),
    .i_rst                (rst),
    .i_inst_valid         (i_inst_valid),
    .i_inst               (i_inst),
    .o_inst_ready         (o_inst_ready),
    .o_ret_valid          (o_ret_valid),
    .i_ret_ready          (i_ret_ready),
    .o_ret_rd             (o_ret_rd),
    .o_ret_data           (o_ret_data),
    .o_ret_wen            (o_ret_wen),
    .o_ret_illegal        (o_ret_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // random bits and instruction encoding
  ////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic pick_reg(output reg_addr_t r, input logic nonzero);
    logic [31:0] b;
    take_bits(stim_lfsr, 5, b);
    r = b[4:0];
    if (nonzero && (r == 5'd0)) begin
      r = 5'd1;
    end
  endtask

  // k 0..9 register ops, 10..18 immediate ops, 19 lui
  function automatic inst_t make_inst(input int k, input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input logic [19:0] imm);
    logic [2:0] f3_tab [10];
    logic       alt_tab [10];
    int         idx;
    f3_tab  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    alt_tab = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    if (k < 10) begin
      make_inst = {(alt_tab[k] ? 7'h20 : 7'h00), rs2, rs1, f3_tab[k], rd, OPC_OP};
    end else if (k < 19) begin
      idx = (k == 10) ? 0 : k - 9;                      // skip sub
      if ((f3_tab[idx] == 3'd1) || (f3_tab[idx] == 3'd5)) begin
        make_inst = {(alt_tab[idx] ? 6'b010000 : 6'b000000), imm[5:0], rs1, f3_tab[idx], rd,
                     OPC_OP_IMM};
      end else begin
        make_inst = {imm[11:0], rs1, f3_tab[idx], rd, OPC_OP_IMM};
      end
    end else begin
      make_inst = {imm, rd, OPC_LUI};
    end
  endfunction

  // expected result from the rv64 integer rules
  function automatic void ref_exec(input inst_t inst, output xlen_t res, output logic wen,
                                   output logic ill);
    xlen_t      a;
    xlen_t      b;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    a   = model_regs[inst[19:15]];
    b   = model_regs[inst[24:20]];
    f3  = inst[14:12];
    f7  = inst[31:25];
    alt = 1'b0;
    ill = 1'b0;
    res = '0;
    case (inst[6:0])
      7'b0110011: begin
        ill = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
        alt = f7[5];
      end
      7'b0010011: begin
        b = {{(XLEN-12){inst[31]}}, inst[31:20]};
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin    // shamt is 6 bits on rv64
          ill = !((inst[31:26] == 6'd0) || ((f3 == 3'd5) && (inst[31:26] == 6'b010000)));
          alt = inst[30];
        end
      end
      7'b0110111: begin
        b  = {{(XLEN-32){inst[31]}}, inst[31:12], 12'h000};
        f3 = 3'd6;
        a  = '0;                                   // 0 | imm
      end
      default: ill = 1'b1;
    endcase
    case (f3)
      3'd0: if (alt) res = a - b; else res = a + b;
      3'd1: res = a << b[5:0];
      3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: res = (a < b) ? 64'd1 : 64'd0;
      3'd4: res = a ^ b;
      3'd5: if (alt) res = $signed(a) >>> b[5:0]; else res = a >> b[5:0];
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    wen = !ill;
  endfunction

  ////////////////////////////////////////
  // checking and reporting
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s at %0t", what, $time);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // outputs are sampled at the falling edge, away from input changes
  always @(negedge clk) begin
    if (!rst) begin
      // ready follows the stall rule of the retire port
      check_value("o_inst_ready", o_inst_ready, !o_ret_valid || i_ret_ready);
      if (held) begin
        check_value("o_ret_valid", o_ret_valid, 1);
        check_value("o_ret_rd", o_ret_rd, snap_rd);
        check_value("o_ret_data", o_ret_data, snap_data);
        check_value("o_ret_wen", o_ret_wen, snap_wen);
        check_value("o_ret_illegal", o_ret_illegal, snap_ill);
      end
      held      = o_ret_valid && !i_ret_ready;
      snap_rd   = o_ret_rd;
      snap_data = o_ret_data;
      snap_wen  = o_ret_wen;
      snap_ill  = o_ret_illegal;
      if (o_ret_valid && i_ret_ready) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("retire seen with no instruction outstanding at %0t", $time);
        end else begin
          exp_e = exp_q.pop_front();
          n_retired++;
          check_value("o_ret_rd", o_ret_rd, exp_e[68:64]);
          check_value("o_ret_wen", o_ret_wen, exp_e[69]);
          check_value("o_ret_illegal", o_ret_illegal, exp_e[70]);
          if (exp_e[69]) begin
            check_value("o_ret_data", o_ret_data, exp_e[63:0]);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (stall_mode) begin
      take_bits(rdy_lfsr, 2, rdy_bits);
      i_ret_ready = (rdy_bits != 0);           // ready three times in four
    end else begin
      i_ret_ready = 1'b1;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic send(input inst_t inst);
    int    t;
    xlen_t res;
    logic  wen;
    logic  ill;
    i_inst_valid = 1'b1;
    i_inst       = inst;
    t = 0;
    @(negedge clk);
    while (!o_inst_ready) begin
      if (t == TIMEOUT) abort_run("instruction never accepted");
      t++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ref_exec(inst, res, wen, ill);
    if (wen && (inst[11:7] != 5'd0)) begin
      model_regs[inst[11:7]] = res;
    end
    exp_q.push_back({ill, wen, inst[11:7], res});
  endtask

  task automatic insert_gap();
    logic [31:0] n;
    logic [31:0] junk;
    take_bits(stim_lfsr, 2, n);
    take_bits(stim_lfsr, 32, junk);
    i_inst_valid = 1'b0;
    i_inst       = junk;                      // garbage under a low valid
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_random(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    logic [31:0] k;
    logic [31:0] imm;
    take_bits(stim_lfsr, 5, k);
    take_bits(stim_lfsr, 20, imm);
    if (gap_mode) begin
      insert_gap();
    end
    send(make_inst(int'(k % 20), rd, rs1, rs2, imm[19:0]));
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err0      = n_errors;
    ret0      = n_retired;
  endtask

  task automatic end_test();
    int t;
    i_inst_valid = 1'b0;
    t = 0;
    while (exp_q.size() != 0) begin
      if (t == TIMEOUT) abort_run("pipeline did not drain");
      t++;
      @(negedge clk);
    end
    repeat (6) @(posedge clk);                // a stray bubble would retire here
    #1;
    $display("test %-12s %0d retired, %0d errors", test_name, n_retired - ret0,
             n_errors - err0);
  endtask

  initial begin
    rst          = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_ret_ready  = 1'b1;
    stall_mode   = 1'b0;
    gap_mode     = 1'b0;
    held         = 1'b0;
    stim_lfsr    = SEED;
    rdy_lfsr     = SEED;
    n_checks     = 0;
    n_errors     = 0;
    n_retired    = 0;
    bad_opc      = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
                     7'b1110011, 7'b0011011, 7'b0111011, 7'b0001111};
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("alu_ops");
    for (int r = 1; r < 32; r++) begin
      take_bits(stim_lfsr, 32, rbits);
      take_bits(stim_lfsr, 6, sbits);
      send(make_inst(19, reg_addr_t'(r), 5'd0, 5'd0, rbits[19:0]));
      send(make_inst(10, reg_addr_t'(r), reg_addr_t'(r), 5'd0, {8'h00, rbits[31:20]}));
      send(make_inst(11, reg_addr_t'(r), reg_addr_t'(r), 5'd0, {14'h0000, sbits[5:0]}));
    end
    for (int k = 0; k < 80; k++) begin
      pick_reg(rd_a, 1'b1);
      pick_reg(rs_a, 1'b0);
      pick_reg(rs_b, 1'b0);
      take_bits(stim_lfsr, 20, rbits);
      send(make_inst(k % 20, rd_a, rs_a, rs_b, rbits[19:0]));
    end
    end_test();

    begin_test("forwarding");
    rd_b = 5'd1;
    rd_c = 5'd2;
    rd_d = 5'd3;
    for (int k = 0; k < 60; k++) begin
      pick_reg(rd_a, 1'b1);
      take_bits(stim_lfsr, 2, sbits);
      send_random(rd_a, sbits[0] ? rd_b : rd_d, sbits[1] ? rd_c : rd_b);
      rd_d = rd_c;
      rd_c = rd_b;
      rd_b = rd_a;
    end
    end_test();

    begin_test("backpressure");
    stall_mode = 1'b1;
    for (int k = 0; k < 80; k++) begin
      pick_reg(rd_a, 1'b1);
      pick_reg(rs_a, 1'b0);
      pick_reg(rs_b, 1'b0);
      send_random(rd_a, rs_a, rs_b);
    end
    end_test();
    stall_mode = 1'b0;

    begin_test("x0_writes");
    for (int k = 0; k < 12; k++) begin
      pick_reg(rs_a, 1'b0);
      pick_reg(rs_b, 1'b0);
      send_random(5'd0, rs_a, rs_b);
      pick_reg(rd_a, 1'b1);
      send_random(rd_a, 5'd0, 5'd0);          // x0 read right behind the write
    end
    end_test();

    begin_test("illegal_ops");
    for (int k = 0; k < 16; k++) begin
      take_bits(stim_lfsr, 32, rbits);
      take_bits(stim_lfsr, 3, sbits);
      if (k % 2) begin
        bad_inst = {rbits[31:7], bad_opc[sbits[2:0]]};
      end else begin
        bad_inst = {rbits[31:25] | 7'h01, rbits[24:7], OPC_OP};  // funct7 never 0 or 0x20
      end
      send(bad_inst);
      pick_reg(rd_a, 1'b1);
      send(make_inst(0, rd_a, bad_inst[11:7], 5'd0, 20'h00000));
    end
    end_test();

    begin_test("bubbles");
    stall_mode = 1'b1;
    gap_mode   = 1'b1;
    for (int k = 0; k < 60; k++) begin
      pick_reg(rd_a, 1'b1);
      pick_reg(rs_a, 1'b0);
      pick_reg(rs_b, 1'b0);
      send_random(rd_a, rs_a, rs_b);
    end
    end_test();
    stall_mode = 1'b0;
    gap_mode   = 1'b0;

    $display("total %0d retired, %0d checks, %0d errors, %0d assertion failures", n_retired,
             n_checks, n_errors, i_dut.u_riscv_datapath_sva.n_fail);
    if ((n_errors == 0) && (i_dut.u_riscv_datapath_sva.n_fail == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/riscv_datapath_sva.sv */
`timescale 1ns/100ps

module riscv_datapath_sva
  import riscv_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst,
  input logic      i_ret_valid,
  input logic      i_ret_ready,
  input reg_addr_t i_ret_rd,
  input xlen_t     i_ret_data,
  input logic      i_ret_wen,
  input logic      i_ret_illegal
);

  int unsigned n_fail = 0;   // failed assertions so far

  // a stalled retire keeps its whole payload
  a_ret_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ret_valid && !i_ret_ready) |=> (i_ret_valid && $stable(i_ret_rd) &&
      $stable(i_ret_data) && $stable(i_ret_wen) && $stable(i_ret_illegal)))
    else begin
      $error("retire outputs changed while stalled");
      n_fail++;
    end

  a_reset_empty: assert property (@(posedge i_clk) i_rst |=> !i_ret_valid)
    else begin
      $error("retire valid high after reset");
      n_fail++;
    end

  a_wen_illegal: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_ret_wen && i_ret_illegal))
    else begin
      $error("write enable set on a flagged instruction");
      n_fail++;
    end

endmodule

bind riscv_datapath riscv_datapath_sva u_riscv_datapath_sva (
  .i_clk         (i_riscv_datapath_clk),
  .i_rst         (i_rst),
  .i_ret_valid   (o_ret_valid),
  .i_ret_ready   (i_ret_ready),
  .i_ret_rd      (o_ret_rd),
  .i_ret_data    (o_ret_data),
  .i_ret_wen     (o_ret_wen),
  .i_ret_illegal (o_ret_illegal)
);

/* verilog/riscv_datapath.sv */
`timescale 1ns/100ps

module riscv_datapath
  import riscv_pkg::*;
(
  input  logic      i_riscv_datapath_clk,
  input  logic      i_rst,
  input  logic      i_inst_valid,
  input  inst_t     i_inst,
  output logic      o_inst_ready,
  output logic      o_ret_valid,
  input  logic      i_ret_ready,
  output reg_addr_t o_ret_rd,
  output xlen_t     o_ret_data,
  output logic      o_ret_wen,
  output logic      o_ret_illegal
);

  logic      advance;     // whole pipeline moves one step
  logic      ret_fire;

  // decode outputs
  reg_addr_t dec_rs1, dec_rs2, dec_rd;
  xlen_t     dec_imm;
  logic      dec_use_imm;
  alu_op_e   dec_alu_op;
  logic      dec_wen;
  logic      dec_illegal;
  xlen_t     rf_rs1_data, rf_rs2_data;

  // decode/execute
  logic      de_valid, de_wen, de_illegal, de_use_imm;
  reg_addr_t de_rs1, de_rs2, de_rd;
  xlen_t     de_rs1_data, de_rs2_data, de_imm;
  alu_op_e   de_alu_op;
  fwd_sel_e  fwd_a, fwd_b;
  xlen_t     alu_res;

  // execute/memory and memory/writeback
  logic      em_valid, em_wen, em_illegal;
  reg_addr_t em_rd;
  xlen_t     em_res;
  logic      mw_valid, mw_wen, mw_illegal;
  reg_addr_t mw_rd;
  xlen_t     mw_res;

  ////////////////////////////////////////
  // handshake and stall
  ////////////////////////////////////////

  assign advance      = ~mw_valid | i_ret_ready;
  assign ret_fire     = mw_valid & i_ret_ready;
  assign o_inst_ready = advance;

  ////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////

  riscv_decoder u_riscv_decoder (
    .i_inst    (i_inst),
    .o_rs1     (dec_rs1),
    .o_rs2     (dec_rs2),
    .o_rd      (dec_rd),
    .o_imm     (dec_imm),
    .o_use_imm (dec_use_imm),
    .o_alu_op  (dec_alu_op),
    .o_wen     (dec_wen),
    .o_illegal (dec_illegal)
  );

  riscv_regfile u_riscv_regfile (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst                (i_rst),
    .i_rs1                (dec_rs1),
    .i_rs2                (dec_rs2),
    .o_rs1_data           (rf_rs1_data),
    .o_rs2_data           (rf_rs2_data),
    .i_we                 (ret_fire & mw_wen),   // commit only on a retire edge
    .i_wa                 (mw_rd),
    .i_wd                 (mw_res)
  );

  // control bits, bubbles carry zero write enable
  always_ff @(posedge i_riscv_datapath_clk) begin
    if (i_rst) begin
      de_valid   <= 1'b0;
      de_wen     <= 1'b0;
      de_illegal <= 1'b0;
      em_valid   <= 1'b0;
      em_wen     <= 1'b0;
      em_illegal <= 1'b0;
      mw_valid   <= 1'b0;
      mw_wen     <= 1'b0;
      mw_illegal <= 1'b0;
    end else if (advance) begin
      de_valid   <= i_inst_valid;
      de_wen     <= i_inst_valid & dec_wen;
      de_illegal <= i_inst_valid & dec_illegal;
      em_valid   <= de_valid;
      em_wen     <= de_wen;
      em_illegal <= de_illegal;
      mw_valid   <= em_valid;
      mw_wen     <= em_wen;
      mw_illegal <= em_illegal;
    end
  end

  // payload of all three stage registers
  always_ff @(posedge i_riscv_datapath_clk) begin
    if (advance) begin
      de_rs1      <= dec_rs1;
      de_rs2      <= dec_rs2;
      de_rd       <= dec_rd;
      de_rs1_data <= rf_rs1_data;
      de_rs2_data <= rf_rs2_data;
      de_imm      <= dec_imm;
      de_use_imm  <= dec_use_imm;
      de_alu_op   <= dec_alu_op;
      em_rd       <= de_rd;
      em_res      <= alu_res;
      mw_rd       <= em_rd;
      mw_res      <= em_res;   // memory stage is a plain hop
    end
  end

  ////////////////////////////////////////
  // execute stage
  ////////////////////////////////////////

  riscv_fwd_unit u_riscv_fwd_unit (
    .i_rs1_e (de_rs1),
    .i_rs2_e (de_rs2),
    .i_rd_m  (em_rd),
    .i_wen_m (em_wen),
    .i_rd_w  (mw_rd),
    .i_wen_w (mw_wen),
    .o_fwd_a (fwd_a),
    .o_fwd_b (fwd_b)
  );

  riscv_alu u_riscv_alu (
    .i_rs1_data (de_rs1_data),
    .i_rs2_data (de_rs2_data),
    .i_res_m    (em_res),
    .i_res_w    (mw_res),
    .i_imm      (de_imm),
    .i_fwd_a    (fwd_a),
    .i_fwd_b    (fwd_b),
    .i_use_imm  (de_use_imm),
    .i_alu_op   (de_alu_op),
    .o_result   (alu_res)
  );

  // retire port straight from writeback
  assign o_ret_valid   = mw_valid;
  assign o_ret_rd      = mw_rd;
  assign o_ret_data    = mw_res;
  assign o_ret_wen     = mw_wen;
  assign o_ret_illegal = mw_illegal;

endmodule

/* verilog/riscv_fwd_unit.sv */
`timescale 1ns/100ps

module riscv_fwd_unit
  import riscv_pkg::*;
(
  input  reg_addr_t i_rs1_e,
  input  reg_addr_t i_rs2_e,
  input  reg_addr_t i_rd_m,
  input  logic      i_wen_m,   // already qualified by stage valid
  input  reg_addr_t i_rd_w,
  input  logic      i_wen_w,
  output fwd_sel_e  o_fwd_a,
  output fwd_sel_e  o_fwd_b
);

  logic hit_m;   // memory stage can supply a result
  logic hit_w;

  assign hit_m = i_wen_m && (i_rd_m != '0);
  assign hit_w = i_wen_w && (i_rd_w != '0);

  // youngest producer first, so memory beats writeback
  function automatic fwd_sel_e pick(reg_addr_t rs);
    if (hit_m && (i_rd_m == rs)) begin
      pick = FWD_MEM;
    end else if (hit_w && (i_rd_w == rs)) begin
      pick = FWD_WB;
    end else begin
      pick = FWD_REG;
    end
  endfunction

  assign o_fwd_a = pick(i_rs1_e);
  assign o_fwd_b = pick(i_rs2_e);

endmodule

/* verilog/riscv_alu.sv */
`timescale 1ns/100ps

module riscv_alu
  import riscv_pkg::*;
(
  input  xlen_t    i_rs1_data,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_res_m,
  input  xlen_t    i_res_w,
  input  xlen_t    i_imm,
  input  fwd_sel_e i_fwd_a,
  input  fwd_sel_e i_fwd_b,
  input  logic     i_use_imm,
  input  alu_op_e  i_alu_op,
  output xlen_t    o_result
);

  xlen_t      op_a;
  xlen_t      fwd_b_data;
  xlen_t      op_b;
  logic [5:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // one forwarding mux, used for both operands
  function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_data);
    case (sel)
      FWD_MEM: fwd_mux = i_res_m;
      FWD_WB:  fwd_mux = i_res_w;
      default: fwd_mux = reg_data;
    endcase
  endfunction

  assign op_a       = fwd_mux(i_fwd_a, i_rs1_data);
  assign fwd_b_data = fwd_mux(i_fwd_b, i_rs2_data);
  assign op_b       = i_use_imm ? i_imm : fwd_b_data;  // imm wins over forwarding

  assign shamt       = op_b[5:0];                      // rv64 shift range
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   o_result = op_a + op_b;
      ALU_SUB:   o_result = op_a - op_b;
      ALU_AND:   o_result = op_a & op_b;
      ALU_OR:    o_result = op_a | op_b;
      ALU_XOR:   o_result = op_a ^ op_b;
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_SLL:   o_result = op_a << shamt;
      ALU_SRL:   o_result = op_a >> shamt;
      ALU_SRA:   o_result = $signed(op_a) >>> shamt;
      ALU_PASSB: o_result = op_b;
      default:   o_result = '0;
    endcase
  end

endmodule

/* verilog/riscv_regfile.sv */
`timescale 1ns/100ps

module riscv_regfile
  import riscv_pkg::*;
(
  input  logic      i_riscv_datapath_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  input  logic      i_we,
  input  reg_addr_t i_wa,
  input  xlen_t     i_wd
);

  xlen_t regs_q [1:31];   // x0 has no storage
  logic  wr_ok;
  logic  byp_rs1;
  logic  byp_rs2;

  assign wr_ok = i_we && (i_wa != '0);   // writes to x0 dropped

  always_ff @(posedge i_riscv_datapath_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_ok) begin
      regs_q[i_wa] <= i_wd;
    end
  end

  // same-cycle write shows up on the read port
  assign byp_rs1 = wr_ok && (i_wa == i_rs1);
  assign byp_rs2 = wr_ok && (i_wa == i_rs2);

  assign o_rs1_data = (i_rs1 == '0) ? '0 :
                      byp_rs1       ? i_wd : regs_q[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 :
                      byp_rs2       ? i_wd : regs_q[i_rs2];

endmodule

/* verilog/riscv_decoder.sv */
`timescale 1ns/100ps

module riscv_decoder
  import riscv_pkg::*;
(
  input  inst_t     i_inst,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output xlen_t     o_imm,
  output logic      o_use_imm,
  output alu_op_e   o_alu_op,
  output logic      o_wen,
  output logic      o_illegal
);

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  logic      alt_ok;     // funct3 that allows the alternate funct7
  logic      f7_bad;
  logic      shamt_bad;  // upper imm bits of an I-type shift
  logic      dec_wen;
  logic      dec_illegal;
  xlen_t     imm_i;
  xlen_t     imm_u;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rd  = i_inst[11:7];
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};  // lui sign-extends on rv64

  assign alt_ok    = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
  assign f7_bad    = !((funct7 == F7_BASE) || ((funct7 == F7_ALT) && alt_ok));
  // rv64 shifts keep a 6-bit shamt, so only bits 31:26 are checked
  assign shamt_bad = (i_inst[31:26] != 6'b000000) &&
                     !((funct3 == F3_SRL_SRA) && (i_inst[31:26] == 6'b010000));

  always_comb begin
    o_alu_op    = ALU_ADD;
    o_use_imm   = 1'b0;
    o_imm       = imm_i;
    dec_wen     = 1'b0;
    dec_illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec_wen     = 1'b1;
        dec_illegal = f7_bad;
        case (funct3)
          F3_ADD_SUB: o_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          F3_SLL:     o_alu_op = ALU_SLL;
          F3_SLT:     o_alu_op = ALU_SLT;
          F3_SLTU:    o_alu_op = ALU_SLTU;
          F3_XOR:     o_alu_op = ALU_XOR;
          F3_SRL_SRA: o_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          F3_OR:      o_alu_op = ALU_OR;
          default:    o_alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        dec_wen   = 1'b1;
        o_use_imm = 1'b1;
        case (funct3)
          F3_ADD_SUB: o_alu_op = ALU_ADD;   // addi only, no subi
          F3_SLL:     o_alu_op = ALU_SLL;
          F3_SLT:     o_alu_op = ALU_SLT;
          F3_SLTU:    o_alu_op = ALU_SLTU;
          F3_XOR:     o_alu_op = ALU_XOR;
          F3_SRL_SRA: o_alu_op = i_inst[30] ? ALU_SRA : ALU_SRL;
          F3_OR:      o_alu_op = ALU_OR;
          default:    o_alu_op = ALU_AND;
        endcase
        if ((funct3 == F3_SLL) || (funct3 == F3_SRL_SRA)) begin
          dec_illegal = shamt_bad;
        end
      end
      OPC_LUI: begin
        dec_wen   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = imm_u;
        o_alu_op  = ALU_PASSB;
      end
      default: dec_illegal = 1'b1;       // anything else retires flagged
    endcase
  end

  assign o_wen     = dec_wen & ~dec_illegal;  // flagged ops never write
  assign o_illegal = dec_illegal;

endmodule

/* verilog/riscv_pkg.sv */
package riscv_pkg;

  ////////////////////////////////////////
  // widths and plain vector types
  ////////////////////////////////////////

  localparam int XLEN = 64;              // datapath width

  typedef logic [XLEN-1:0] xlen_t;       // register value or operand
  typedef logic [31:0]     inst_t;       // instruction word
  typedef logic [4:0]      reg_addr_t;   // register index
  typedef logic [6:0]      opcode_t;     // major opcode field
  typedef logic [2:0]      funct3_t;     // minor opcode field
  typedef logic [6:0]      funct7_t;     // upper function field

  ////////////////////////////////////////
  // opcode and function encodings
  ////////////////////////////////////////

  localparam opcode_t OPC_OP     = 7'b0110011;  // register-register
  localparam opcode_t OPC_OP_IMM = 7'b0010011;  // register-immediate
  localparam opcode_t OPC_LUI    = 7'b0110111;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct7_t F7_BASE    = 7'h00;  // add, srl and the rest
  localparam funct7_t F7_ALT     = 7'h20;  // sub and sra only

  ////////////////////////////////////////
  // control enums
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLT   = 4'd5,
    ALU_SLTU  = 4'd6,
    ALU_SLL   = 4'd7,
    ALU_SRL   = 4'd8,
    ALU_SRA   = 4'd9,
    ALU_PASSB = 4'd10   // operand b straight through, for lui
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,     // value captured at decode
    FWD_MEM = 2'd1,     // result sitting in the memory stage
    FWD_WB  = 2'd2      // result sitting in writeback
  } fwd_sel_e;

endpackage
